/* common/ilk_pkg.sv */
// shared definitions for the interlaken transmit front end
// holds beat geometry, the end-of-packet code union, control word
// layout, serializer states and the register map

package ilk_pkg;

   // beat and word geometry
   localparam int unsigned beat_words     = 8;
   localparam int unsigned word_bits      = 64;
   localparam int unsigned beat_bits      = beat_words * word_bits; // 512
   localparam int unsigned cnt_bits       = 4;                      // holds 0..8
   localparam int unsigned empty_bits     = 6;                      // avalon empty in bytes
   localparam int unsigned word_byte_bits = 3;                      // byte select in a word
   localparam int unsigned idx_bits       = $clog2(beat_words);     // word index in a beat

   // end-of-packet code seen as a raw nibble or as flag plus byte count
   localparam int unsigned eop_bits = 4;

   typedef union packed {
      logic [eop_bits-1:0] raw;
      struct packed {
         logic                      eop_end;   // packet ends here
         logic [word_byte_bits-1:0] eop_bytes; // valid bytes in last word where 0 means 8
      } f;
   } ilk_eop_t;

   localparam logic [eop_bits-1:0] eop_none  = 4'b0000;
   localparam logic [eop_bits-1:0] eop_error = 4'b0001; // flag clear with count 1

   // control word fields
   localparam int unsigned ctrl_sop_bit  = 63; // set in the start word only
   localparam int unsigned ctrl_eop_lsb  = 0;  // eop code in the end word only
   localparam int unsigned ctrl_chan_lsb = 8;  // channel in both words
   localparam int unsigned chan_bits     = 8;

   // serializer phases
   localparam int unsigned state_bits = 2;
   localparam logic [state_bits-1:0] st_idle  = 2'd0;
   localparam logic [state_bits-1:0] st_start = 2'd1;
   localparam logic [state_bits-1:0] st_data  = 2'd2;
   localparam logic [state_bits-1:0] st_end   = 2'd3;

   // register map
   localparam int unsigned reg_bits      = 32;
   localparam int unsigned reg_addr_bits = 2;
   localparam logic [reg_addr_bits-1:0] reg_addr_ctrl = 2'd0;
   localparam logic [reg_addr_bits-1:0] reg_addr_pkts = 2'd1;
   localparam logic [reg_addr_bits-1:0] reg_addr_errs = 2'd2;

   // control register fields
   localparam int unsigned reg_en_bit   = 0;
   localparam int unsigned reg_chan_lsb = 8;

endpackage

/* avl_to_ilk/avl_to_ilk_adapter.sv */
// avalon-st to interlaken sideband adapter
// decodes empty, eop and error of a beat into a valid word count and a
// 4-bit eop code; data, sop, valid and ready go straight through
// purely combinational, zero latency

`timescale 1ns/1ps

module avl_to_ilk_adapter (
   // avalon side
   input  logic [ilk_pkg::beat_bits-1:0]  avl_data,
   input  logic                           avl_sop,
   input  logic                           avl_eop,
   input  logic                           avl_valid,
   input  logic [ilk_pkg::empty_bits-1:0] avl_empty,
   input  logic                           avl_error,
   output logic                           avl_ready,

   // interlaken side
   output logic [ilk_pkg::beat_bits-1:0]  ilk_data,
   output logic [ilk_pkg::cnt_bits-1:0]   ilk_num_valid,
   output logic                           ilk_sop,
   output ilk_pkg::ilk_eop_t              ilk_eop,
   output logic                           ilk_valid,
   input  logic                           ilk_ready
);

   import ilk_pkg::*;

   logic [cnt_bits-1:0]       full_words; // 8 - empty/8, rounded down
   logic [word_byte_bits-1:0] empty_lo;   // byte part of empty
   logic                      aligned;    // empty lands on a word boundary

   assign empty_lo   = avl_empty[word_byte_bits-1:0];
   assign aligned    = (empty_lo == '0);
   assign full_words = cnt_bits'(beat_words)
                     - cnt_bits'(avl_empty[empty_bits-1:word_byte_bits]);

   // sideband decode
   always_comb begin
      ilk_num_valid = '0;        // nothing valid by default
      ilk_eop.raw   = eop_none;

      if (avl_valid) begin
         if (!avl_eop) begin
            // mid packet, only whole words may be empty
            if (aligned)
               ilk_num_valid = full_words;
         end else begin
            // last beat, a partly filled word still counts as a word
            ilk_num_valid = full_words;
            if (avl_error) begin
               ilk_eop.raw = eop_error;
            end else begin
               ilk_eop.f.eop_end   = 1'b1;
               ilk_eop.f.eop_bytes = '0 - empty_lo; // 8 - n mod 8, 0 means all 8
            end
         end
      end
   end

   // pass-through of payload and handshake
   assign ilk_data  = avl_data;
   assign ilk_sop   = avl_sop;
   assign ilk_valid = avl_valid;
   assign avl_ready = ilk_ready; // back-pressure from serializer

   // source protocol checks, evaluated once values settle
   always_comb begin
      if (avl_valid && !avl_eop) begin
         a_mid_empty_aligned: assert final (aligned)
            else $error("adapter: empty %0d not word aligned in non-eop beat", avl_empty);
      end
      if (!avl_valid) begin
         a_marks_need_valid: assert final (!avl_sop && !avl_eop)
            else $error("adapter: sop/eop high without valid");
      end
   end

endmodule

/* ilk_tx/ilk_word_serializer.sv */
// interlaken word serializer
// holds one accepted beat and sends it out one 64-bit word per cycle:
// start control word (on sop), the valid data words lowest first, then
// an end control word carrying the eop code; words advance on tx_ready

`timescale 1ns/1ps

module ilk_word_serializer (
   input  logic                          clk,
   input  logic                          rst_n,

   // beat input from adapter
   input  logic [ilk_pkg::beat_bits-1:0] ilk_data,
   input  logic [ilk_pkg::cnt_bits-1:0]  ilk_num_valid,
   input  logic                          ilk_sop,
   input  ilk_pkg::ilk_eop_t             ilk_eop,
   input  logic                          ilk_valid,
   output logic                          ilk_ready,

   // configuration
   input  logic                          tx_enable,
   input  logic [ilk_pkg::chan_bits-1:0] tx_channel,

   // word output
   output logic [ilk_pkg::word_bits-1:0] tx_word,
   output logic                          tx_ctrl,
   output logic                          tx_valid,
   input  logic                          tx_ready,

   // statistics pulses
   output logic                          pkt_done,
   output logic                          pkt_err
);

   import ilk_pkg::*;

   logic [state_bits-1:0] state_q, state_d;
   logic [idx_bits-1:0]   idx_q;      // current data word
   logic [beat_bits-1:0]  data_q;     // held beat
   logic [cnt_bits-1:0]   cnt_q;      // words to send from it
   ilk_eop_t              eop_q;
   logic [chan_bits-1:0]  chan_q;     // channel frozen per beat
   logic                  accept;
   logic                  last_word;
   logic                  is_err;
   logic [word_bits-1:0]  ctrl_word;

   // phase that follows once the start word (if any) is out
   function automatic logic [state_bits-1:0] next_phase(
      input logic [cnt_bits-1:0] cnt,
      input logic [eop_bits-1:0] code
   );
      if (cnt != '0)
         return st_data;
      else if (code != eop_none)
         return st_end;
      else
         return st_idle; // nothing to send
   endfunction

   assign ilk_ready = (state_q == st_idle) && tx_enable; // buffer empty
   assign accept    = ilk_valid && ilk_ready;
   assign tx_valid  = (state_q != st_idle);
   assign tx_ctrl   = (state_q == st_start) || (state_q == st_end);
   assign last_word = (cnt_bits'(idx_q) + cnt_bits'(1)) == cnt_q;

   // error end seen through the flag/count view: flag clear, count 1
   assign is_err   = !eop_q.f.eop_end && (eop_q.f.eop_bytes == word_byte_bits'(1));
   assign pkt_done = (state_q == st_end) && tx_ready;
   assign pkt_err  = pkt_done && is_err;

   // phase sequencing
   always_comb begin
      state_d = state_q;
      case (state_q)
         st_idle: begin
            if (accept)
               state_d = ilk_sop ? st_start : next_phase(ilk_num_valid, ilk_eop.raw);
         end
         st_start: begin
            if (tx_ready)
               state_d = next_phase(cnt_q, eop_q.raw);
         end
         st_data: begin
            if (tx_ready && last_word)
               state_d = next_phase('0, eop_q.raw); // end word or done
         end
         st_end: begin
            if (tx_ready)
               state_d = st_idle;
         end
         default: state_d = st_idle;
      endcase
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state_q <= st_idle;
         idx_q   <= '0;
      end else begin
         state_q <= state_d;
         if (accept)
            idx_q <= '0;
         else if ((state_q == st_data) && tx_ready && !last_word)
            idx_q <= idx_q + 1'b1; // next word of the beat
      end
   end

   // beat buffer, loaded on accept only
   always_ff @(posedge clk) begin
      if (accept) begin
         data_q <= ilk_data;
         cnt_q  <= ilk_num_valid;
         eop_q  <= ilk_eop;
         chan_q <= tx_channel;
      end
   end

   // control word build, channel in both, sop bit or eop code
   always_comb begin
      ctrl_word = '0;
      ctrl_word[ctrl_chan_lsb +: chan_bits] = chan_q;
      if (state_q == st_start)
         ctrl_word[ctrl_sop_bit] = 1'b1;
      else
         ctrl_word[ctrl_eop_lsb +: eop_bits] = eop_q.raw;
   end

   always_comb begin
      tx_word = data_q[idx_q*word_bits +: word_bits]; // data phase word
      if (tx_ctrl)
         tx_word = ctrl_word;
   end

   // a stalled word must not move
   a_hold_on_stall: assert property (@(posedge clk) disable iff (!rst_n)
      tx_valid && !tx_ready |=> tx_valid && $stable(tx_word) && $stable(tx_ctrl))
      else $error("serializer: output changed while stalled");

   // a beat with something to send fills the buffer, so no second accept
   a_one_beat_held: assert property (@(posedge clk) disable iff (!rst_n)
      accept && (ilk_sop || (ilk_num_valid != '0) || (ilk_eop.raw != eop_none))
      |=> !ilk_ready)
      else $error("serializer: ready high with beat buffer full");

endmodule

/* ilk_tx/ilk_tx_regs.sv */
// transmit configuration and statistics registers
// control word holds enable and channel for the serializer; two wrapping
// counters track finished and errored packets and clear on a write
// read data is a combinational mux on the address

`timescale 1ns/1ps

module ilk_tx_regs (
   input  logic                              clk,
   input  logic                              rst_n,

   // register port
   input  logic                              reg_wr,
   input  logic [ilk_pkg::reg_addr_bits-1:0] reg_addr,
   input  logic [ilk_pkg::reg_bits-1:0]      reg_wdata,
   output logic [ilk_pkg::reg_bits-1:0]      reg_rdata,

   // serializer side
   input  logic                              pkt_done,
   input  logic                              pkt_err,
   output logic                              tx_enable,
   output logic [ilk_pkg::chan_bits-1:0]     tx_channel
);

   import ilk_pkg::*;

   logic [reg_bits-1:0] pkts_q; // end words sent
   logic [reg_bits-1:0] errs_q; // error ends among them
   logic                wr_ctrl, wr_pkts, wr_errs;

   assign wr_ctrl = reg_wr && (reg_addr == reg_addr_ctrl);
   assign wr_pkts = reg_wr && (reg_addr == reg_addr_pkts);
   assign wr_errs = reg_wr && (reg_addr == reg_addr_errs);

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         tx_enable  <= 1'b0;
         tx_channel <= '0;
         pkts_q     <= '0;
         errs_q     <= '0;
      end else begin
         if (wr_ctrl) begin
            tx_enable  <= reg_wdata[reg_en_bit];
            tx_channel <= reg_wdata[reg_chan_lsb +: chan_bits];
         end

         if (wr_pkts)
            pkts_q <= '0;            // clear wins over a count
         else if (pkt_done)
            pkts_q <= pkts_q + 1'b1; // wraps

         if (wr_errs)
            errs_q <= '0;
         else if (pkt_err)
            errs_q <= errs_q + 1'b1;
      end
   end

   // read mux
   always_comb begin
      reg_rdata = '0; // unused addresses read 0
      case (reg_addr)
         reg_addr_ctrl: begin
            reg_rdata[reg_en_bit]                 = tx_enable;
            reg_rdata[reg_chan_lsb +: chan_bits]  = tx_channel;
         end
         reg_addr_pkts: reg_rdata = pkts_q;
         reg_addr_errs: reg_rdata = errs_q;
         default:       reg_rdata = '0;
      endcase
   end

endmodule

/* src/ilk_tx_top.sv */
// interlaken transmit front end, top level
// avalon-st beats go through the sideband adapter into the word
// serializer; a register block sets enable and channel and counts packets

`timescale 1ns/1ps

module ilk_tx_top (
   input  logic                              clk,
   input  logic                              rst_n,

   // avalon-st sink
   input  logic [ilk_pkg::beat_bits-1:0]     avl_data,
   input  logic                              avl_sop,
   input  logic                              avl_eop,
   input  logic                              avl_valid,
   input  logic [ilk_pkg::empty_bits-1:0]    avl_empty,
   input  logic                              avl_error,
   output logic                              avl_ready,

   // word output
   output logic [ilk_pkg::word_bits-1:0]     tx_word,
   output logic                              tx_ctrl,
   output logic                              tx_valid,
   input  logic                              tx_ready,

   // register port
   input  logic                              reg_wr,
   input  logic [ilk_pkg::reg_addr_bits-1:0] reg_addr,
   input  logic [ilk_pkg::reg_bits-1:0]      reg_wdata,
   output logic [ilk_pkg::reg_bits-1:0]      reg_rdata
);

   import ilk_pkg::*;

   // adapter to serializer
   logic [beat_bits-1:0] ilk_data;
   logic [cnt_bits-1:0]  ilk_num_valid;
   logic                 ilk_sop;
   ilk_eop_t             ilk_eop;
   logic                 ilk_valid;
   logic                 ilk_ready;

   // registers to and from serializer
   logic                 tx_enable;
   logic [chan_bits-1:0] tx_channel;
   logic                 pkt_done;
   logic                 pkt_err;

   avl_to_ilk_adapter i_adapter (
      .avl_data      (avl_data),
      .avl_sop       (avl_sop),
      .avl_eop       (avl_eop),
      .avl_valid     (avl_valid),
      .avl_empty     (avl_empty),
      .avl_error     (avl_error),
      .avl_ready     (avl_ready),
      .ilk_data      (ilk_data),
      .ilk_num_valid (ilk_num_valid),
      .ilk_sop       (ilk_sop),
      .ilk_eop       (ilk_eop),
      .ilk_valid     (ilk_valid),
      .ilk_ready     (ilk_ready)
   );

   ilk_word_serializer i_serializer (
      .clk           (clk),
      .rst_n         (rst_n),
      .ilk_data      (ilk_data),
      .ilk_num_valid (ilk_num_valid),
      .ilk_sop       (ilk_sop),
      .ilk_eop       (ilk_eop),
      .ilk_valid     (ilk_valid),
      .ilk_ready     (ilk_ready),
      .tx_enable     (tx_enable),
      .tx_channel    (tx_channel),
      .tx_word       (tx_word),
      .tx_ctrl       (tx_ctrl),
      .tx_valid      (tx_valid),
      .tx_ready      (tx_ready),
      .pkt_done      (pkt_done),
      .pkt_err       (pkt_err)
   );

   ilk_tx_regs i_regs (
      .clk        (clk),
      .rst_n      (rst_n),
      .reg_wr     (reg_wr),
      .reg_addr   (reg_addr),
      .reg_wdata  (reg_wdata),
      .reg_rdata  (reg_rdata),
      .pkt_done   (pkt_done),
      .pkt_err    (pkt_err),
      .tx_enable  (tx_enable),
      .tx_channel (tx_channel)
   );

endmodule

/* test/tb_ilk_tx_tasks.svh */
// directed tests for the interlaken transmit front end
// beat and register drivers, expected word builders and one task per
// behavior; included inside the testbench module

// words in a beat, from empty and eop
function automatic int word_count(input logic eop, input logic [empty_bits-1:0] empty);
   if (eop || (empty % 8 == 0))
      return 8 - empty / 8;   // rounded down on eop
   return 0;                  // misaligned mid-packet beat carries nothing
endfunction

// eop code, built through the flag/count view or the raw view
function automatic logic [3:0] end_code(input logic error, input logic [empty_bits-1:0] empty);
   ilk_eop_t c;
   int       bytes;
   bytes = (8 - empty % 8) % 8;
   c.raw = eop_none;
   if (error) begin
      c.raw = eop_error;
   end else begin
      c.f.eop_end   = 1'b1;
      c.f.eop_bytes = 3'(bytes);
   end
   return c.raw;
endfunction

function automatic logic [63:0] start_word(input logic [7:0] chan);
   logic [63:0] w;
   w = '0;
   w[ctrl_sop_bit] = 1'b1;
   w[ctrl_chan_lsb +: 8] = chan;
   return w;
endfunction

function automatic logic [63:0] end_word(input logic [7:0] chan, input logic [3:0] code);
   logic [63:0] w;
   w = '0;
   w[ctrl_chan_lsb +: 8] = chan;
   w[ctrl_eop_lsb +: 4] = code;
   return w;
endfunction

task automatic release_inputs();
   @(negedge clk);
   avl_valid = 1'b0;
   avl_sop   = 1'b0;
   avl_eop   = 1'b0;
   avl_error = 1'b0;
   avl_empty = '0;
endtask

// drive one beat and hold it until accepted
task automatic send_beat(input logic [beat_bits-1:0] data, input logic sop, input logic eop,
                         input logic [empty_bits-1:0] empty, input logic error);
   @(negedge clk);
   avl_data  = data;
   avl_sop   = sop;
   avl_eop   = eop;
   avl_empty = empty;
   avl_error = error;
   avl_valid = 1'b1;
   @(posedge clk);
   while (!avl_ready)
      @(posedge clk);
endtask

// random payload, expected words pushed before each beat goes out
task automatic send_packet(input int nbeats, input logic [empty_bits-1:0] last_empty,
                           input logic error);
   logic [beat_bits-1:0]  data;
   logic [empty_bits-1:0] empty;
   logic                  eop;
   int                    n;
   for (int b = 0; b < nbeats; b++) begin
      eop   = (b == nbeats - 1);
      empty = eop ? last_empty : '0;
      for (int w = 0; w < beat_words; w++)
         data[w*64 +: 64] = rand_bits(64);
      n = word_count(eop, empty);
      if (b == 0)
         exp_q.push_back({1'b1, start_word(cur_chan)});
      for (int w = 0; w < n; w++)
         exp_q.push_back({1'b0, data[w*64 +: 64]}); // lowest word first
      if (eop) begin
         exp_q.push_back({1'b1, end_word(cur_chan, end_code(error, empty))});
         exp_pkts++;
         if (error)
            exp_errs++;
      end
      send_beat(data, b == 0, eop, empty, error && eop);
   end
   release_inputs();
endtask

task automatic wait_drain();
   int t;
   t = 0;
   while ((exp_q.size() != 0 || tx_valid) && t < drain_limit) begin
      @(negedge clk);
      t++;
   end
   assert (exp_q.size() == 0 && !tx_valid)
      else begin
         seq_errs++;
         $display("words still pending after %0d cycles, %0d expected words never seen",
                  t, exp_q.size());
      end
   exp_q.delete();
endtask

task automatic reg_write(input logic [1:0] addr, input logic [31:0] data);
   @(negedge clk);
   reg_wr    = 1'b1;
   reg_addr  = addr;
   reg_wdata = data;
   @(negedge clk);
   reg_wr = 1'b0;
endtask

task automatic reg_check(input logic [1:0] addr, input logic [31:0] exp, input string name);
   @(negedge clk);
   reg_addr = addr;
   @(posedge clk);
   assert (reg_rdata == exp)
      else begin
         val_errs++;
         $display("ERR %s exp %h got %h", name, exp, reg_rdata);
      end
endtask

task automatic set_ctrl(input logic en, input logic [7:0] chan);
   logic [31:0] d;
   d = '0;
   d[reg_en_bit] = en;
   d[reg_chan_lsb +: 8] = chan;
   reg_write(reg_addr_ctrl, d);
   cur_chan = chan;
endtask

task automatic ready_check(input logic exp);
   @(posedge clk);
   assert (avl_ready == exp && !tx_valid)
      else begin
         val_errs++;
         $display("ERR avl_ready exp %h got %h (tx_valid %h)", exp, avl_ready, tx_valid);
      end
endtask

task automatic reset_and_register_test();
   ready_check(1'b0);
   reg_check(reg_addr_pkts, 32'h0, "pkt_count");
   reg_check(reg_addr_errs, 32'h0, "err_count");
   reg_check(reg_addr_ctrl, 32'h0, "ctrl");
   set_ctrl(1'b0, 8'h5a);
   reg_check(reg_addr_ctrl, 32'h0000_5a00, "ctrl");
   reg_check(2'd3, 32'h0, "unused");
   repeat (3)
      ready_check(1'b0);   // still disabled
   set_ctrl(1'b1, 8'h5a);
   reg_check(reg_addr_ctrl, 32'h0000_5a01, "ctrl");
   ready_check(1'b1);
endtask

task automatic full_packet_test();
   send_packet(3, 6'd0, 1'b0); // 24 data words, end code 1000
   wait_drain();
   reg_check(reg_addr_pkts, exp_pkts, "pkt_count");
endtask

task automatic short_beat_test();
   for (int i = 0; i < 6; i++)
      send_packet(1, 6'(rand_bits(6)), 1'b0);
   send_packet(2, 6'(rand_bits(6)), 1'b0);
   wait_drain();
   reg_check(reg_addr_pkts, exp_pkts, "pkt_count");
endtask

task automatic error_packet_test();
   send_packet(1, 6'(rand_bits(6)), 1'b1);
   send_packet(2, 6'(rand_bits(6)), 1'b1);
   wait_drain();
   reg_check(reg_addr_pkts, exp_pkts, "pkt_count");
   reg_check(reg_addr_errs, exp_errs, "err_count");
   reg_write(reg_addr_pkts, 32'h0);
   exp_pkts = 0;
   reg_check(reg_addr_pkts, 32'h0, "pkt_count");
   reg_check(reg_addr_errs, exp_errs, "err_count");
   reg_write(reg_addr_errs, 32'h0);
   exp_errs = 0;
   reg_check(reg_addr_errs, 32'h0, "err_count");
endtask

// same packets twice, unstalled then stalled, output must match
task automatic backpressure_test();
   logic [31:0]      saved;
   logic [word_bits:0] ref_q[$];
   int               n;
   set_ctrl(1'b1, 8'h3c);
   saved = rnd_state;
   got_q.delete();
   capture_on = 1'b1;
   for (int pass = 0; pass < 2; pass++) begin
      rnd_state = saved;   // replay the same payload
      stall_on  = (pass == 1);
      send_packet(2, 6'(rand_bits(6)), 1'b0);
      send_packet(1, 6'(rand_bits(6)), 1'b0);
      send_packet(3, 6'(rand_bits(6)), 1'b0);
      wait_drain();
      if (pass == 0) begin
         ref_q = got_q;
         got_q.delete();
      end
   end
   stall_on   = 1'b0;
   capture_on = 1'b0;
   assert (got_q.size() == ref_q.size())
      else begin
         seq_errs++;
         $display("stalled run gave %0d words, unstalled run %0d", got_q.size(), ref_q.size());
      end
   n = (got_q.size() < ref_q.size()) ? got_q.size() : ref_q.size();
   for (int i = 0; i < n; i++)
      assert (got_q[i] == ref_q[i])
         else begin
            val_errs++;
            $display("ERR tx_ctrl/tx_word[%0d] exp %h got %h", i, ref_q[i], got_q[i]);
         end
endtask

task automatic disable_test();
   set_ctrl(1'b0, cur_chan);
   @(negedge clk);
   avl_data  = {beat_words{rand_bits(64)}};
   avl_sop   = 1'b1;
   avl_eop   = 1'b1;
   avl_empty = '0;
   avl_valid = 1'b1;   // offered but never taken
   repeat (20)
      ready_check(1'b0);
   release_inputs();
   reg_check(reg_addr_pkts, exp_pkts, "pkt_count");
endtask

/* test/tb_ilk_tx_top.sv */
// testbench for the interlaken transmit front end
// drives avalon-st beats and register accesses, checks every transmitted
// word against an expected queue built from the adapter and serializer rules

`timescale 1ns/1ps

module tb_ilk_tx_top;

   import ilk_pkg::*;

   localparam int unsigned total_beats    = 26;                    // beats over all tests
   localparam int unsigned timeout_cycles = total_beats * 40 + 600; // plus register traffic
   localparam int unsigned drain_limit    = 400;
   localparam logic [31:0] lfsr_seed      = 32'h04a56bda;

   logic                     clk;
   logic                     rst_n;
   logic [beat_bits-1:0]     avl_data;
   logic                     avl_sop;
   logic                     avl_eop;
   logic                     avl_valid;
   logic [empty_bits-1:0]    avl_empty;
   logic                     avl_error;
   logic                     avl_ready;
   logic [word_bits-1:0]     tx_word;
   logic                     tx_ctrl;
   logic                     tx_valid;
   logic                     tx_ready;
   logic                     reg_wr;
   logic [reg_addr_bits-1:0] reg_addr;
   logic [reg_bits-1:0]      reg_wdata;
   logic [reg_bits-1:0]      reg_rdata;

   logic [word_bits:0]   exp_q[$];  // {ctrl, word} in send order
   logic [word_bits:0]   got_q[$];  // captured output, backpressure test
   logic [word_bits:0]   exp_word;
   logic [31:0]          rnd_state; // data and empty values
   logic [31:0]          rdy_state; // tx_ready pattern, own stream
   logic                 stall_on;
   logic                 capture_on;
   logic [chan_bits-1:0] cur_chan;
   int                   exp_pkts;
   int                   exp_errs;
   int                   val_errs;  // wrong values
   int                   seq_errs;  // missing or extra words

   ilk_tx_top i_ilk_tx_top (
      .clk       (clk),
      .rst_n     (rst_n),
      .avl_data  (avl_data),
      .avl_sop   (avl_sop),
      .avl_eop   (avl_eop),
      .avl_valid (avl_valid),
      .avl_empty (avl_empty),
      .avl_error (avl_error),
      .avl_ready (avl_ready),
      .tx_word   (tx_word),
      .tx_ctrl   (tx_ctrl),
      .tx_valid  (tx_valid),
      .tx_ready  (tx_ready),
      .reg_wr    (reg_wr),
      .reg_addr  (reg_addr),
      .reg_wdata (reg_wdata),
      .reg_rdata (reg_rdata)
   );

   always #50 clk = ~clk; // 100 ns period

   // galois lfsr, x^32 + x^22 + x^2 + x + 1
   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
   endfunction

   // one lfsr step per bit taken
   function automatic logic [63:0] rand_bits(input int n);
      logic [63:0] r;
      r = '0;
      for (int i = 0; i < n; i++) begin
         rnd_state = lfsr_next(rnd_state);
         r = {r[62:0], rnd_state[0]};
      end
      return r;
   endfunction

   // tx_ready pattern, stepped once per cycle while stalling
   always @(negedge clk) begin
      if (stall_on) begin
         rdy_state = lfsr_next(rdy_state);
         tx_ready  = rdy_state[0];
      end else begin
         tx_ready = 1'b1;
      end
   end

   // output monitor, one transfer per rising edge
   always @(posedge clk) begin
      if (rst_n) begin
         assert (!(tx_valid && avl_ready)) // one beat held at a time
            else begin
               val_errs++;
               $display("ERR avl_ready exp %h got %h", 1'b0, avl_ready);
            end
         if (tx_valid && tx_ready) begin
            if (capture_on)
               got_q.push_back({tx_ctrl, tx_word});
            assert (exp_q.size() != 0)
               else begin
                  seq_errs++;
                  $display("unexpected word %h (ctrl %0d) with nothing expected", tx_word, tx_ctrl);
               end
            if (exp_q.size() != 0) begin
               exp_word = exp_q.pop_front();
               assert (tx_ctrl == exp_word[word_bits])
                  else begin
                     val_errs++;
                     $display("ERR tx_ctrl exp %h got %h", exp_word[word_bits], tx_ctrl);
                  end
               assert (tx_word == exp_word[word_bits-1:0])
                  else begin
                     val_errs++;
                     $display("ERR tx_word exp %h got %h", exp_word[word_bits-1:0], tx_word);
                  end
            end
         end
      end
   end

   `include "tb_ilk_tx_tasks.svh"

   // watchdog
   initial begin
      repeat (timeout_cycles) @(posedge clk);
      $display("watchdog expired after %0d cycles, run stopped", timeout_cycles);
      $display("** FAIL **");
      $finish;
   end

   initial begin
      clk        = 1'b0;
      rst_n      = 1'b0;
      avl_data   = '0;
      avl_sop    = 1'b0;
      avl_eop    = 1'b0;
      avl_valid  = 1'b0;
      avl_empty  = '0;
      avl_error  = 1'b0;
      tx_ready   = 1'b1;
      reg_wr     = 1'b0;
      reg_addr   = '0;
      reg_wdata  = '0;
      rnd_state  = lfsr_seed;
      rdy_state  = lfsr_seed;
      stall_on   = 1'b0;
      capture_on = 1'b0;
      cur_chan   = '0;
      exp_pkts   = 0;
      exp_errs   = 0;
      val_errs   = 0;
      seq_errs   = 0;

      repeat (5) @(posedge clk); // reset for 5 cycles
      @(negedge clk);
      rst_n = 1'b1;

      reset_and_register_test();
      full_packet_test();
      short_beat_test();
      error_packet_test();
      backpressure_test();
      disable_test();

      $display("checks done: %0d value errors, %0d other errors", val_errs, seq_errs);
      if (val_errs == 0 && seq_errs == 0)
         $display("** PASS **");
      else
         $display("** FAIL **");
      $finish;
   end

endmodule

/* files.f */
+incdir+test
common/ilk_pkg.sv
avl_to_ilk/avl_to_ilk_adapter.sv
ilk_tx/ilk_word_serializer.sv
ilk_tx/ilk_tx_regs.sv
src/ilk_tx_top.sv
test/tb_ilk_tx_top.sv
